// ==== hw/pcie_pkg.sv ====
package pcie_pkg;

    // register pages, one per application
    localparam int MAX_NB_APPS   = 4;
    localparam int APP_IDX_WIDTH = 2;
    localparam int REGS_PER_PAGE = 4;
    localparam int NB_PIO_REGS   = 16;
    localparam int DWORD_BYTES   = 4;

    // BAR0 layout
    localparam int PCIE_ADDR_WIDTH = 16;
    localparam int PAGE_LSB        = 12;
    localparam int RB_BRAM_OFFSET  = 256;
    localparam int RB_LINE_AWIDTH  = 10;

    // queue table, field 0 tails, 1 heads, 2 kmem_low, 3 kmem_high
    localparam int QT_DWIDTH      = 32;
    localparam int QT_FIELD_WIDTH = 2;

    // status bus
    localparam int STAT_SEL_WIDTH  = 2;
    localparam int STAT_PCIE_SEL   = 1;
    localparam int STAT_REG_AWIDTH = 8;

    // scheduler FSM encoding
    localparam logic [1:0] IDLE         = 2'd0;
    localparam logic [1:0] RAM_WAIT_1   = 2'd1;
    localparam logic [1:0] RAM_WAIT_2   = 2'd2;
    localparam logic [1:0] SWITCH_QUEUE = 2'd3;

    // control word, raw from the status bus or split into fields
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [4:0]  total_nb_queues;
            logic [25:0] rb_size;
            logic        disable_pcie;
        } fld;
    } ctrl_reg_u;

endpackage

// ==== hw/qtable_ram.sv ====
`timescale 1ns/1ps

module qtable_ram (
    input  logic                               pcie_clk,
    input  logic [pcie_pkg::APP_IDX_WIDTH-1:0] addr_a,
    input  logic [pcie_pkg::APP_IDX_WIDTH-1:0] addr_b,
    input  logic [pcie_pkg::QT_DWIDTH-1:0]     wdata_a,
    input  logic [pcie_pkg::QT_DWIDTH-1:0]     wdata_b,
    input  logic                               we_a,
    input  logic                               we_b,
    input  logic                               rden_b,
    output logic [pcie_pkg::QT_DWIDTH-1:0]     rdata_b
);
    import pcie_pkg::*;

    logic [QT_DWIDTH-1:0]     mem [MAX_NB_APPS];
    logic [APP_IDX_WIDTH-1:0] addr_b_r;

    always_ff @(posedge pcie_clk) begin
        if (we_a) begin
            mem[addr_a] <= wdata_a;
        end
        if (we_b) begin
            mem[addr_b] <= wdata_b;
        end
        // address register then output register, like the block RAM
        if (rden_b) begin
            addr_b_r <= addr_b;
        end
        rdata_b <= mem[addr_b_r];
    end

endmodule

// ==== hw/queue_table.sv ====
`timescale 1ns/1ps

module queue_table (
    input  logic                                pcie_clk,
    input  logic                                pcie_reset_n,
    input  logic                                tail_we,
    input  logic [pcie_pkg::APP_IDX_WIDTH-1:0]  tail_idx,
    input  logic [pcie_pkg::QT_DWIDTH-1:0]      tail_wdata,
    input  logic                                bar_we,
    input  logic [pcie_pkg::QT_FIELD_WIDTH-1:0] bar_field,
    input  logic [pcie_pkg::APP_IDX_WIDTH-1:0]  bar_idx,
    input  logic [pcie_pkg::QT_DWIDTH-1:0]      bar_wdata,
    input  logic                                rd_req,
    input  logic [pcie_pkg::QT_FIELD_WIDTH-1:0] rd_field,
    input  logic [pcie_pkg::APP_IDX_WIDTH-1:0]  rd_idx,
    output logic [pcie_pkg::QT_DWIDTH-1:0]      rd_data,
    output logic                                rd_valid
);
    import pcie_pkg::*;

    logic                      pend_valid;
    logic [QT_FIELD_WIDTH-1:0] pend_field;
    logic [APP_IDX_WIDTH-1:0]  pend_idx;
    logic                      rd_go;
    logic [QT_FIELD_WIDTH-1:0] go_field;
    logic [APP_IDX_WIDTH-1:0]  go_idx;
    logic [1:0]                go_pipe;
    logic [QT_FIELD_WIDTH-1:0] field_r1;
    logic [QT_FIELD_WIDTH-1:0] field_r2;
    logic [QT_DWIDTH-1:0]      q_b [REGS_PER_PAGE];

    // a new request skips the pending register when port B is free
    assign go_field = rd_req ? rd_field : pend_field;
    assign go_idx   = rd_req ? rd_idx : pend_idx;
    assign rd_go    = (rd_req || pend_valid) && !bar_we;

    for (genvar f = 0; f < REGS_PER_PAGE; f++) begin : g_field
        // port A only carries the scheduler's tail writes
        qtable_ram i_qtable_ram (
            .pcie_clk (pcie_clk),
            .addr_a   (tail_idx),
            .addr_b   (bar_we ? bar_idx : go_idx),
            .wdata_a  (tail_wdata),
            .wdata_b  (bar_wdata),
            .we_a     ((f == 0) && tail_we),
            .we_b     (bar_we && (bar_field == f)),
            .rden_b   (rd_go && (go_field == f)),
            .rdata_b  (q_b[f])
        );
    end

    always_ff @(posedge pcie_clk) begin
        if (rd_req) begin
            pend_field <= rd_field;
            pend_idx   <= rd_idx;
        end
        // field number follows the two RAM cycles
        field_r1 <= go_field;
        field_r2 <= field_r1;
        rd_data  <= q_b[field_r2];
    end

    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            pend_valid <= 1'b0;
            go_pipe    <= '0;
            rd_valid   <= 1'b0;
        end else begin
            // BAR0 writes own port B, the read waits
            pend_valid <= (rd_req || pend_valid) && bar_we;
            go_pipe    <= {go_pipe[0], rd_go};
            rd_valid   <= go_pipe[1];
        end
    end

endmodule

// ==== hw/pio_regs.sv ====
`timescale 1ns/1ps

module pio_regs (
    input  logic                                 pcie_clk,
    input  logic                                 pcie_reset_n,
    input  logic [pcie_pkg::PCIE_ADDR_WIDTH-1:0] address_0,
    input  logic                                 read_0,
    input  logic                                 write_0,
    input  logic [511:0]                         writedata_0,
    input  logic [63:0]                          byteenable_0,
    output logic [511:0]                         readdata_0,
    output logic                                 readdatavalid_0,
    output logic                                 frb_read,
    output logic [pcie_pkg::RB_LINE_AWIDTH-1:0]  frb_address,
    input  logic [511:0]                         frb_readdata,
    input  logic                                 frb_readvalid,
    input  logic [pcie_pkg::QT_DWIDTH-1:0]       tails [pcie_pkg::MAX_NB_APPS],
    output logic [pcie_pkg::QT_DWIDTH-1:0]       heads [pcie_pkg::MAX_NB_APPS],
    output logic [pcie_pkg::QT_DWIDTH-1:0]       kmem_low [pcie_pkg::MAX_NB_APPS],
    output logic [pcie_pkg::QT_DWIDTH-1:0]       kmem_high [pcie_pkg::MAX_NB_APPS],
    output logic                                 bar_we,
    output logic [pcie_pkg::QT_FIELD_WIDTH-1:0]  bar_field,
    output logic [pcie_pkg::APP_IDX_WIDTH-1:0]   bar_idx,
    output logic [pcie_pkg::QT_DWIDTH-1:0]       bar_wdata
);
    import pcie_pkg::*;

    logic [QT_DWIDTH-1:0]      wr_regs [NB_PIO_REGS];
    logic [QT_DWIDTH-1:0]      pio_view [NB_PIO_REGS];
    logic [APP_IDX_WIDTH-1:0]  page;
    logic [APP_IDX_WIDTH-1:0]  page_r1;
    logic [APP_IDX_WIDTH-1:0]  page_r2;
    logic [APP_IDX_WIDTH-1:0]  qt_page;
    logic [RB_LINE_AWIDTH-1:0] line;
    logic                      reg_region;
    logic                      region_r1;
    logic                      region_r2;
    logic                      read_r1;
    logic                      read_r2;
    logic                      reg_rd;
    logic [REGS_PER_PAGE-1:0]  wr_mask;
    logic [REGS_PER_PAGE-1:0]  qt_pend;
    logic [QT_FIELD_WIDTH-1:0] qt_sel;

    assign page        = address_0[PAGE_LSB +: APP_IDX_WIDTH];
    assign line        = address_0[PCIE_ADDR_WIDTH-1 -: RB_LINE_AWIDTH];
    assign reg_region  = line < RB_LINE_AWIDTH'(RB_BRAM_OFFSET);
    assign frb_read    = read_0 && !reg_region;
    assign frb_address = line - RB_LINE_AWIDTH'(RB_BRAM_OFFSET);
    assign reg_rd      = region_r2 && read_r2;

    always_comb begin
        // dword 0 is the tail and never takes a CPU write
        wr_mask = '0;
        for (int i = 1; i < REGS_PER_PAGE; i++) begin
            wr_mask[i] = &byteenable_0[i*DWORD_BYTES +: DWORD_BYTES];
        end
        // lowest pending field goes to the table first
        qt_sel = '0;
        for (int i = REGS_PER_PAGE - 1; i > 0; i--) begin
            if (qt_pend[i]) begin
                qt_sel = QT_FIELD_WIDTH'(i);
            end
        end
    end

    always_comb begin
        for (int p = 0; p < MAX_NB_APPS; p++) begin
            pio_view[p*REGS_PER_PAGE] = tails[p];
            for (int k = 1; k < REGS_PER_PAGE; k++) begin
                pio_view[p*REGS_PER_PAGE+k] = wr_regs[p*REGS_PER_PAGE+k];
            end
            heads[p]     = wr_regs[p*REGS_PER_PAGE+1];
            kmem_low[p]  = wr_regs[p*REGS_PER_PAGE+2];
            kmem_high[p] = wr_regs[p*REGS_PER_PAGE+3];
        end
    end

    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            wr_regs <= '{default: '0};
            qt_pend <= '0;
            bar_we  <= 1'b0;
        end else begin
            bar_we <= |qt_pend;
            if (|qt_pend) begin
                qt_pend[qt_sel] <= 1'b0;
            end
            // a new write restarts the table update for its own page
            if (write_0) begin
                for (int i = 1; i < REGS_PER_PAGE; i++) begin
                    if (wr_mask[i]) begin
                        wr_regs[page*REGS_PER_PAGE+i] <=
                            writedata_0[i*QT_DWIDTH +: QT_DWIDTH];
                    end
                end
                qt_pend <= wr_mask;
                qt_page <= page;
            end
        end
    end

    always_ff @(posedge pcie_clk) begin
        bar_field <= qt_sel;
        bar_idx   <= qt_page;
        bar_wdata <= wr_regs[qt_page*REGS_PER_PAGE+qt_sel];
    end

    // two stage read delay, then register or ring-buffer data
    always_ff @(posedge pcie_clk) begin
        region_r1 <= reg_region;
        region_r2 <= region_r1;
        page_r1   <= page;
        page_r2   <= page_r1;
        if (reg_rd) begin
            readdata_0 <= {384'h0,
                           pio_view[page_r2*REGS_PER_PAGE+3],
                           pio_view[page_r2*REGS_PER_PAGE+2],
                           pio_view[page_r2*REGS_PER_PAGE+1],
                           pio_view[page_r2*REGS_PER_PAGE]};
        end else begin
            readdata_0 <= frb_readdata;
        end
        if (!pcie_reset_n) begin
            read_r1         <= 1'b0;
            read_r2         <= 1'b0;
            readdatavalid_0 <= 1'b0;
        end else begin
            read_r1         <= read_0;
            read_r2         <= read_r1;
            readdatavalid_0 <= reg_rd || frb_readvalid;
        end
    end

endmodule

// ==== hw/queue_sched.sv ====
`timescale 1ns/1ps

module queue_sched (
    input  logic                               pcie_clk,
    input  logic                               pcie_reset_n,
    input  logic                               dma_done,
    input  logic [pcie_pkg::QT_DWIDTH-1:0]     new_tail,
    input  logic [4:0]                         total_nb_queues,
    input  logic [pcie_pkg::QT_DWIDTH-1:0]     heads [pcie_pkg::MAX_NB_APPS],
    input  logic [pcie_pkg::QT_DWIDTH-1:0]     kmem_low [pcie_pkg::MAX_NB_APPS],
    input  logic [pcie_pkg::QT_DWIDTH-1:0]     kmem_high [pcie_pkg::MAX_NB_APPS],
    output logic [pcie_pkg::QT_DWIDTH-1:0]     tails [pcie_pkg::MAX_NB_APPS],
    output logic [pcie_pkg::QT_DWIDTH-1:0]     f2c_tail,
    output logic [pcie_pkg::QT_DWIDTH-1:0]     f2c_head,
    output logic [63:0]                        f2c_kmem_addr,
    output logic                               tail_we,
    output logic [pcie_pkg::APP_IDX_WIDTH-1:0] tail_idx,
    output logic [pcie_pkg::QT_DWIDTH-1:0]     tail_wdata
);
    import pcie_pkg::*;

    logic [1:0]               state;
    logic [APP_IDX_WIDTH-1:0] queue_id;
    logic [APP_IDX_WIDTH-1:0] next_q;

    // round robin over 0 .. total_nb_queues-1
    always_comb begin
        if (total_nb_queues <= 5'd1 || 5'(queue_id) == total_nb_queues - 5'd1) begin
            next_q = '0;
        end else begin
            next_q = queue_id + 1'b1;
        end
    end

    always_ff @(posedge pcie_clk) begin
        f2c_tail      <= tails[queue_id];
        f2c_head      <= heads[queue_id];
        f2c_kmem_addr <= {kmem_high[queue_id], kmem_low[queue_id]};
        tail_idx      <= queue_id;
        tail_wdata    <= tails[queue_id];
        if (!pcie_reset_n) begin
            state    <= IDLE;
            queue_id <= '0;
            tails    <= '{default: '0};
            tail_we  <= 1'b0;
        end else begin
            tail_we <= 1'b0;
            case (state)
                IDLE: begin
                    if (dma_done) begin
                        tails[queue_id] <= new_tail;
                        state           <= RAM_WAIT_1;
                    end
                end
                RAM_WAIT_1: state <= RAM_WAIT_2;
                RAM_WAIT_2: state <= SWITCH_QUEUE;
                SWITCH_QUEUE: begin
                    // store the finished queue's tail, then move on
                    tail_we  <= 1'b1;
                    queue_id <= next_q;
                    state    <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== hw/status_regs.sv ====
`timescale 1ns/1ps

module status_regs (
    input  logic                                pcie_clk,
    input  logic                                pcie_reset_n,
    input  logic [29:0]                         status_addr,
    input  logic                                status_read,
    input  logic                                status_write,
    input  logic [31:0]                         status_writedata,
    output logic [31:0]                         status_readdata,
    output logic                                status_readdata_valid,
    output pcie_pkg::ctrl_reg_u                 ctrl,
    output logic                                rd_req,
    output logic [pcie_pkg::QT_FIELD_WIDTH-1:0] rd_field,
    output logic [pcie_pkg::APP_IDX_WIDTH-1:0]  rd_idx,
    input  logic [pcie_pkg::QT_DWIDTH-1:0]      rd_data,
    input  logic                                rd_valid
);
    import pcie_pkg::*;

    logic [29:0]                addr_r;
    logic                       read_r;
    logic                       write_r;
    logic [31:0]                wdata_r;
    logic                       hit;
    logic [STAT_REG_AWIDTH-1:0] reg_off;
    logic [STAT_REG_AWIDTH-1:0] tbl_ent;

    assign hit     = addr_r[29 -: STAT_SEL_WIDTH] == STAT_SEL_WIDTH'(STAT_PCIE_SEL);
    assign reg_off = addr_r[STAT_REG_AWIDTH-1:0];
    // table entries start at offset 1, four fields per queue
    assign tbl_ent = reg_off - 1'b1;

    always_ff @(posedge pcie_clk) begin
        addr_r  <= status_addr;
        wdata_r <= status_writedata;
        if (!pcie_reset_n) begin
            read_r                <= 1'b0;
            write_r               <= 1'b0;
            status_readdata_valid <= 1'b0;
            rd_req                <= 1'b0;
            ctrl                  <= '0;
        end else begin
            read_r                <= status_read;
            write_r               <= status_write;
            status_readdata_valid <= 1'b0;
            rd_req                <= 1'b0;
            if (rd_valid) begin
                status_readdata       <= rd_data;
                status_readdata_valid <= 1'b1;
            end
            if (hit && read_r) begin
                if (reg_off == '0) begin
                    status_readdata       <= ctrl.raw;
                    status_readdata_valid <= 1'b1;
                end else begin
                    rd_req   <= 1'b1;
                    rd_field <= tbl_ent[QT_FIELD_WIDTH-1:0];
                    rd_idx   <= tbl_ent[QT_FIELD_WIDTH +: APP_IDX_WIDTH];
                end
            end
            if (hit && write_r && reg_off == '0) begin
                ctrl.raw <= wdata_r;
            end
        end
    end

endmodule

// ==== hw/pcie_top.sv ====
`timescale 1ns/1ps

module pcie_top (
    input  logic                                 pcie_clk,
    input  logic                                 pcie_reset_n,
    input  logic [pcie_pkg::PCIE_ADDR_WIDTH-1:0] address_0,
    input  logic                                 read_0,
    input  logic                                 write_0,
    input  logic [511:0]                         writedata_0,
    input  logic [63:0]                          byteenable_0,
    output logic [511:0]                         readdata_0,
    output logic                                 readdatavalid_0,
    output logic                                 frb_read,
    output logic [pcie_pkg::RB_LINE_AWIDTH-1:0]  frb_address,
    input  logic [511:0]                         frb_readdata,
    input  logic                                 frb_readvalid,
    input  logic                                 dma_done,
    input  logic [pcie_pkg::QT_DWIDTH-1:0]       new_tail,
    output logic [pcie_pkg::QT_DWIDTH-1:0]       f2c_tail,
    output logic [pcie_pkg::QT_DWIDTH-1:0]       f2c_head,
    output logic [63:0]                          f2c_kmem_addr,
    input  logic [29:0]                          status_addr,
    input  logic                                 status_read,
    input  logic                                 status_write,
    input  logic [31:0]                          status_writedata,
    output logic [31:0]                          status_readdata,
    output logic                                 status_readdata_valid,
    output logic                                 disable_pcie,
    output logic [25:0]                          rb_size
);
    import pcie_pkg::*;

    ctrl_reg_u                 ctrl;
    logic [QT_DWIDTH-1:0]      tails [MAX_NB_APPS];
    logic [QT_DWIDTH-1:0]      heads [MAX_NB_APPS];
    logic [QT_DWIDTH-1:0]      kmem_low [MAX_NB_APPS];
    logic [QT_DWIDTH-1:0]      kmem_high [MAX_NB_APPS];
    logic                      bar_we;
    logic [QT_FIELD_WIDTH-1:0] bar_field;
    logic [APP_IDX_WIDTH-1:0]  bar_idx;
    logic [QT_DWIDTH-1:0]      bar_wdata;
    logic                      tail_we;
    logic [APP_IDX_WIDTH-1:0]  tail_idx;
    logic [QT_DWIDTH-1:0]      tail_wdata;
    logic                      rd_req;
    logic [QT_FIELD_WIDTH-1:0] rd_field;
    logic [APP_IDX_WIDTH-1:0]  rd_idx;
    logic [QT_DWIDTH-1:0]      rd_data;
    logic                      rd_valid;

    assign disable_pcie = ctrl.fld.disable_pcie;
    assign rb_size      = ctrl.fld.rb_size;

    pio_regs i_pio_regs (
        .pcie_clk, .pcie_reset_n,
        .address_0, .read_0, .write_0, .writedata_0, .byteenable_0,
        .readdata_0, .readdatavalid_0,
        .frb_read, .frb_address, .frb_readdata, .frb_readvalid,
        .tails, .heads, .kmem_low, .kmem_high,
        .bar_we, .bar_field, .bar_idx, .bar_wdata
    );

    queue_table i_queue_table (
        .pcie_clk, .pcie_reset_n,
        .tail_we, .tail_idx, .tail_wdata,
        .bar_we, .bar_field, .bar_idx, .bar_wdata,
        .rd_req, .rd_field, .rd_idx, .rd_data, .rd_valid
    );

    queue_sched i_queue_sched (
        .pcie_clk, .pcie_reset_n,
        .dma_done, .new_tail,
        .total_nb_queues (ctrl.fld.total_nb_queues),
        .heads, .kmem_low, .kmem_high, .tails,
        .f2c_tail, .f2c_head, .f2c_kmem_addr,
        .tail_we, .tail_idx, .tail_wdata
    );

    status_regs i_status_regs (
        .pcie_clk, .pcie_reset_n,
        .status_addr, .status_read, .status_write, .status_writedata,
        .status_readdata, .status_readdata_valid,
        .ctrl,
        .rd_req, .rd_field, .rd_idx, .rd_data, .rd_valid
    );

endmodule

// ==== testbench/pcie_top_asserts.sv ====
`timescale 1ns/1ps

module pcie_top_asserts (
    input logic pcie_clk,
    input logic pcie_reset_n,
    input logic read_0,
    input logic frb_read,
    input logic readdatavalid_0,
    input logic rd_req,
    input logic rd_valid,
    input logic bar_we,
    input logic tail_we
);

    int   err_cnt = 0;
    logic rd_open;

    // one table read in flight between rd_req and rd_valid
    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            rd_open <= 1'b0;
        end else if (rd_req) begin
            rd_open <= 1'b1;
        end else if (rd_valid) begin
            rd_open <= 1'b0;
        end
    end

    reg_read_latency: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
        read_0 && !frb_read |-> ##3 readdatavalid_0)
    else begin
        $error("register read not answered by readdatavalid_0 three cycles later");
        err_cnt++;
    end

    valid_needs_request: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
        rd_valid |-> rd_open)
    else begin
        $error("queue table rd_valid without an open request");
        err_cnt++;
    end

    // table write enables stay low while reset is held
    write_idle_in_reset: assert property (@(posedge pcie_clk)
        !pcie_reset_n |=> !bar_we && !tail_we)
    else begin
        $error("queue table write enable active during reset");
        err_cnt++;
    end

endmodule

// ==== testbench/tb_pcie_top.sv ====
`timescale 1ns/1ps

module tb_pcie_top;
    import pcie_pkg::*;

    // the whole directed sequence needs a few hundred cycles
    localparam int MAX_CYCLES = 2000;
    localparam int WAIT_LIMIT = 40;
    localparam logic [29:0] STAT_BASE = 30'(STAT_PCIE_SEL) << (30 - STAT_SEL_WIDTH);

    logic                       pcie_clk = 1'b0;
    logic                       pcie_reset_n;
    logic [PCIE_ADDR_WIDTH-1:0] address_0;
    logic                       read_0;
    logic                       write_0;
    logic [511:0]               writedata_0;
    logic [63:0]                byteenable_0;
    logic [511:0]               readdata_0;
    logic                       readdatavalid_0;
    logic                       frb_read;
    logic [RB_LINE_AWIDTH-1:0]  frb_address;
    logic [511:0]               frb_readdata;
    logic                       frb_readvalid;
    logic                       dma_done;
    logic [QT_DWIDTH-1:0]       new_tail;
    logic [QT_DWIDTH-1:0]       f2c_tail;
    logic [QT_DWIDTH-1:0]       f2c_head;
    logic [63:0]                f2c_kmem_addr;
    logic [29:0]                status_addr;
    logic                       status_read;
    logic                       status_write;
    logic [31:0]                status_writedata;
    logic [31:0]                status_readdata;
    logic                       status_readdata_valid;
    logic                       disable_pcie;
    logic [25:0]                rb_size;

    // expected page registers and scheduler tails
    logic [31:0] regs_m [NB_PIO_REGS] = '{default: '0};
    logic [31:0] tails_m [MAX_NB_APPS] = '{default: '0};
    int          cycle_cnt = 0;

    pcie_top i_pcie_top (.*);

    bind pcie_top pcie_top_asserts i_pcie_top_asserts (.*);

    always #4 pcie_clk = ~pcie_clk;

    always @(posedge pcie_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
            $display("STATUS: FAIL");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(input string test, input string what,
                               input logic [511:0] exp, input logic [511:0] act);
        assert (act === exp) else begin
            fail_now($sformatf("error %s %s expected %0h actual %0h", test, what, exp, act));
        end
    endtask

    function automatic logic [511:0] rand_line();
        logic [511:0] v;
        for (int i = 0; i < 16; i++) begin
            v[i*32 +: 32] = $urandom();
        end
        return v;
    endfunction

    // dwords 1 to 3 take a write only with all four byte enables set
    task automatic start_write(input int page, input logic [511:0] data,
                               input logic [63:0] be);
        address_0    = PCIE_ADDR_WIDTH'(page << PAGE_LSB);
        writedata_0  = data;
        byteenable_0 = be;
        write_0      = 1'b1;
        for (int i = 1; i < REGS_PER_PAGE; i++) begin
            if (&be[i*DWORD_BYTES +: DWORD_BYTES]) begin
                regs_m[page*REGS_PER_PAGE+i] = data[i*32 +: 32];
            end
        end
    endtask

    // idle cycles let the table updates of the page drain
    task automatic bar_write(input int page, input logic [511:0] data, input logic [63:0] be);
        start_write(page, data, be);
        @(negedge pcie_clk);
        write_0 = 1'b0;
        repeat (4) @(negedge pcie_clk);
    endtask

    task automatic read_page(input string test, input int page, output logic [511:0] data);
        int lat;
        address_0 = PCIE_ADDR_WIDTH'(page << PAGE_LSB);
        read_0    = 1'b1;
        @(negedge pcie_clk);
        read_0 = 1'b0;
        lat    = 1;
        while (!readdatavalid_0) begin
            if (lat >= WAIT_LIMIT) begin
                fail_now("readdatavalid_0 never came for a register read");
            end
            @(negedge pcie_clk);
            lat++;
        end
        data = readdata_0;
        check_value(test, "bar0 read latency", 3, lat);
    endtask

    task automatic check_page(input string test, input int page);
        logic [511:0] data;
        read_page(test, page, data);
        check_value(test, "tail dword", tails_m[page], data[31:0]);
        for (int i = 1; i < REGS_PER_PAGE; i++) begin
            check_value(test, $sformatf("page %0d dword %0d", page, i),
                        regs_m[page*REGS_PER_PAGE+i], data[i*32 +: 32]);
        end
        check_value(test, "upper bits", 0, data[511:128]);
    endtask

    task automatic start_status_read(input int off);
        status_addr = STAT_BASE | 30'(off);
        status_read = 1'b1;
    endtask

    task automatic wait_status(output logic [31:0] data, output int lat);
        lat = 1;
        while (!status_readdata_valid) begin
            if (lat >= WAIT_LIMIT) begin
                fail_now("status_readdata_valid never came for a status read");
            end
            @(negedge pcie_clk);
            lat++;
        end
        data = status_readdata;
    endtask

    task automatic status_read_reg(input int off, output logic [31:0] data, output int lat);
        start_status_read(off);
        @(negedge pcie_clk);
        status_read = 1'b0;
        wait_status(data, lat);
    endtask

    task automatic status_write_reg(input int off, input logic [31:0] data);
        status_addr      = STAT_BASE | 30'(off);
        status_writedata = data;
        status_write     = 1'b1;
        @(negedge pcie_clk);
        status_write = 1'b0;
        @(negedge pcie_clk);
    endtask

    task automatic check_f2c(input string test, input int q);
        check_value(test, $sformatf("f2c_tail q%0d", q), tails_m[q], f2c_tail);
        check_value(test, $sformatf("f2c_head q%0d", q), regs_m[q*4+1], f2c_head);
        check_value(test, $sformatf("f2c_kmem_addr q%0d", q),
                    {regs_m[q*4+3], regs_m[q*4+2]}, f2c_kmem_addr);
    endtask

    task automatic test_ctrl_reg();
        logic [31:0] w;
        logic [31:0] data;
        int          lat;
        check_value("reset", "readdatavalid_0", 0, readdatavalid_0);
        check_value("reset", "status_readdata_valid", 0, status_readdata_valid);
        check_value("reset", "frb_read", 0, frb_read);
        check_value("reset", "disable_pcie", 0, disable_pcie);
        w = $urandom();
        status_write_reg(0, w);
        check_value("ctrl_reg", "disable_pcie", w[0], disable_pcie);
        check_value("ctrl_reg", "rb_size", w[26:1], rb_size);
        status_read_reg(0, data, lat);
        check_value("ctrl_reg", "readback", w, data);
        check_value("ctrl_reg", "latency", 2, lat);
    endtask

    task automatic test_page_write();
        logic [511:0] d;
        for (int p = 0; p < MAX_NB_APPS; p++) begin
            d        = rand_line();
            d[31:0] = d[31:0] | 32'h1;
            bar_write(p, d, '1);
        end
        for (int p = 0; p < MAX_NB_APPS; p++) begin
            check_page("page_write", p);
        end
    endtask

    task automatic test_byte_enables();
        logic [63:0] be;
        be                   = '1;
        be[2*DWORD_BYTES+1] = 1'b0;
        bar_write(1, rand_line(), be);
        check_page("byte_enables", 1);
    endtask

    task automatic test_table_status();
        logic [31:0] data;
        int          lat;
        for (int p = 0; p < MAX_NB_APPS; p++) begin
            for (int f = 1; f < REGS_PER_PAGE; f++) begin
                status_read_reg(1 + p*4 + f, data, lat);
                check_value("table_status", $sformatf("page %0d field %0d", p, f),
                            regs_m[p*4+f], data);
                check_value("table_status", "latency", 6, lat);
            end
        end
        // status read of page 2 head while page 0 is rewritten
        start_write(0, rand_line(), '1);
        start_status_read(1 + 2*4 + 1);
        @(negedge pcie_clk);
        write_0     = 1'b0;
        status_read = 1'b0;
        wait_status(data, lat);
        check_value("table_overlap", "page 2 head", regs_m[9], data);
        assert (lat > 6) else begin
            fail_now("the overlapped status read was not held back by the BAR0 write");
        end
        repeat (4) @(negedge pcie_clk);
        status_read_reg(1 + 3, data, lat);
        check_value("table_overlap", "page 0 kmem_high", regs_m[3], data);
    endtask

    task automatic test_scheduler();
        logic [31:0] data;
        int          lat;
        int          q;
        status_write_reg(0, {5'd3, 26'h0, 1'b0});
        q = 0;
        for (int step = 0; step < 4; step++) begin
            check_f2c("scheduler", q);
            new_tail = $urandom();
            dma_done = 1'b1;
            @(negedge pcie_clk);
            dma_done = 1'b0;
            repeat (5) @(negedge pcie_clk);
            tails_m[q] = new_tail;
            q          = (q + 1) % 3;
        end
        check_f2c("scheduler", q);
        for (int p = 0; p < MAX_NB_APPS; p++) begin
            check_page("scheduler", p);
        end
        // page 3 is outside the three active queues
        for (int p = 0; p < 3; p++) begin
            status_read_reg(1 + p*4, data, lat);
            check_value("scheduler", $sformatf("table tail %0d", p), tails_m[p], data);
        end
    endtask

    task automatic test_ring_buffer();
        logic [511:0] d;
        int           k;
        k         = $urandom_range(0, 767);
        address_0 = PCIE_ADDR_WIDTH'((RB_BRAM_OFFSET + k) << (PCIE_ADDR_WIDTH - RB_LINE_AWIDTH));
        read_0    = 1'b1;
        #1;
        check_value("ring_buffer", "frb_read", 1, frb_read);
        check_value("ring_buffer", "frb_address", k, frb_address);
        @(negedge pcie_clk);
        read_0        = 1'b0;
        d             = rand_line();
        frb_readdata  = d;
        frb_readvalid = 1'b1;
        @(negedge pcie_clk);
        frb_readvalid = 1'b0;
        check_value("ring_buffer", "readdatavalid_0", 1, readdatavalid_0);
        check_value("ring_buffer", "readdata_0", d, readdata_0);
    endtask

    initial begin
        void'($urandom(57358));
        pcie_reset_n     = 1'b0;
        address_0        = '0;
        read_0           = 1'b0;
        write_0          = 1'b0;
        writedata_0      = '0;
        byteenable_0     = '0;
        frb_readdata     = '0;
        frb_readvalid    = 1'b0;
        dma_done         = 1'b0;
        new_tail         = '0;
        status_addr      = '0;
        status_read      = 1'b0;
        status_write     = 1'b0;
        status_writedata = '0;
        repeat (3) @(negedge pcie_clk);
        pcie_reset_n = 1'b1;
        @(negedge pcie_clk);
        test_ctrl_reg();
        test_page_write();
        test_byte_enables();
        test_table_status();
        test_scheduler();
        test_ring_buffer();
        repeat (4) @(negedge pcie_clk);
        if (i_pcie_top.i_pcie_top_asserts.err_cnt != 0) begin
            $display("%0d concurrent assertion failures",
                     i_pcie_top.i_pcie_top_asserts.err_cnt);
            $display("STATUS: FAIL");
        end else begin
            $display("STATUS: PASS");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
hw/pcie_pkg.sv
hw/qtable_ram.sv
hw/queue_table.sv
hw/pio_regs.sv
hw/queue_sched.sv
hw/status_regs.sv
hw/pcie_top.sv
testbench/pcie_top_asserts.sv
testbench/tb_pcie_top.sv
